// File: verilog/csr_pkg.sv
package csr_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int XLEN          = 32;
    localparam int CSR_ADDR_BITS = 12;
    localparam int CSR_TAG_BITS  = 5;  // Micro-op tag
    localparam int CSR_IDX_BITS  = 4;
    localparam int CSR_N_REGS    = 15;

    // Specification addresses
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MHARTID   = 12'hF14;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MISA      = 12'h301;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MSTATUSH  = 12'h310;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ADDR_MCYCLEH   = 12'hB80;

    // Architectural index, read-only registers first
    typedef enum logic [CSR_IDX_BITS-1:0] {
        CSR_MVENDORID = 4'd0,
        CSR_MARCHID   = 4'd1,
        CSR_MIMPID    = 4'd2,
        CSR_MHARTID   = 4'd3,
        CSR_MISA      = 4'd4,
        CSR_MSTATUSH  = 4'd5,
        CSR_MSTATUS   = 4'd6,
        CSR_MIE       = 4'd7,
        CSR_MTVEC     = 4'd8,
        CSR_MSCRATCH  = 4'd9,
        CSR_MEPC      = 4'd10,
        CSR_MCAUSE    = 4'd11,
        CSR_MTVAL     = 4'd12,
        CSR_MCYCLE    = 4'd13,
        CSR_MCYCLEH   = 4'd14
    } csr_idx_e;

    localparam logic [CSR_N_REGS-1:0] CSR_RO_MASK = 15'h003F;  // Indices 0..5

    ////////////////////////////////////////
    // Field positions and reset values
    ////////////////////////////////////////
    localparam int MSTATUS_MIE     = 3;
    localparam int MSTATUS_MPIE    = 7;
    localparam int MSTATUS_MPP_LSB = 11;
    localparam int MSTATUS_MPP_MSB = 12;
    localparam logic [1:0] PRIV_M  = 2'b11;

    localparam logic [XLEN-1:0] MISA_RESET = 32'h40001104;  // RV32 with I, M, C

    typedef struct packed {
        logic     impl;
        csr_idx_e idx;
    } csr_xlat_t;

    function automatic csr_xlat_t csr_translate(input logic [CSR_ADDR_BITS-1:0] addr);
        csr_xlat_t x;
        x.impl = 1'b1;
        case (addr)
            CSR_ADDR_MVENDORID: x.idx = CSR_MVENDORID;
            CSR_ADDR_MARCHID:   x.idx = CSR_MARCHID;
            CSR_ADDR_MIMPID:    x.idx = CSR_MIMPID;
            CSR_ADDR_MHARTID:   x.idx = CSR_MHARTID;
            CSR_ADDR_MSTATUS:   x.idx = CSR_MSTATUS;
            CSR_ADDR_MISA:      x.idx = CSR_MISA;
            CSR_ADDR_MIE:       x.idx = CSR_MIE;
            CSR_ADDR_MTVEC:     x.idx = CSR_MTVEC;
            CSR_ADDR_MSTATUSH:  x.idx = CSR_MSTATUSH;
            CSR_ADDR_MSCRATCH:  x.idx = CSR_MSCRATCH;
            CSR_ADDR_MEPC:      x.idx = CSR_MEPC;
            CSR_ADDR_MCAUSE:    x.idx = CSR_MCAUSE;
            CSR_ADDR_MTVAL:     x.idx = CSR_MTVAL;
            CSR_ADDR_MCYCLE:    x.idx = CSR_MCYCLE;
            CSR_ADDR_MCYCLEH:   x.idx = CSR_MCYCLEH;
            default: begin
                x.impl = 1'b0;
                x.idx  = CSR_MVENDORID;
            end
        endcase
        return x;
    endfunction

    ////////////////////////////////////////
    // Request and response
    ////////////////////////////////////////
    typedef struct packed {
        logic                     valid;
        logic [CSR_ADDR_BITS-1:0] addr;
        logic [CSR_TAG_BITS-1:0]  tag;
    } csr_rd_req_t;

    typedef struct packed {
        logic                     valid;
        logic [CSR_ADDR_BITS-1:0] addr;
        logic [CSR_TAG_BITS-1:0]  tag;
        logic [XLEN-1:0]          data;
    } csr_wr_req_t;

    typedef struct packed {
        logic [XLEN-1:0] data;
        logic            valid;
    } csr_rd_rsp_t;

endpackage

// File: verilog/trap_pkg.sv
package trap_pkg;

    localparam int EXC_CODE_BITS = 5;

    ////////////////////////////////////////
    // Exception codes
    ////////////////////////////////////////
    typedef enum logic [EXC_CODE_BITS-1:0] {
        INSTR_MISALIGNED = 5'd0,
        ILLEGAL_INSTR    = 5'd2,
        BREAKPOINT       = 5'd3,
        LOAD_MISALIGNED  = 5'd4,
        STORE_MISALIGNED = 5'd6,
        ECALL_M          = 5'd11,
        MRET             = 5'd24   // Internal, never written to mcause
    } exc_code_e;

    // Report from one pipeline stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        exc_code_e   code;
        logic [31:0] info;
    } exc_req_t;

    // Fetch redirect, doubles as flush
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    typedef struct packed {
        logic        valid;
        logic        entry;    // 0 means MRET
        logic [31:0] mepc;
        logic [31:0] mcause;
        logic [31:0] mtval;
        logic [31:0] mstatus;
    } trap_upd_t;

endpackage

// File: verilog/csr_file.sv
`timescale 1ns/1ps

module csr_file
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic            clk_i,
    input  logic            rstn_i,

    input  csr_rd_req_t     rd_req_i,
    input  csr_wr_req_t     wr_req_i,
    input  trap_upd_t       trap_upd_i,

    output csr_rd_rsp_t     rd_rsp_o,

    output logic [XLEN-1:0] mstatus_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);

    ////////////////////////////////////////
    // State
    ////////////////////////////////////////
    logic [XLEN-1:0]         data_q  [CSR_N_REGS];
    logic [XLEN-1:0]         data_n  [CSR_N_REGS];
    logic [CSR_TAG_BITS-1:0] tag_q   [CSR_N_REGS];
    logic [CSR_TAG_BITS-1:0] tag_n   [CSR_N_REGS];
    logic [CSR_N_REGS-1:0]   valid_q;
    logic [CSR_N_REGS-1:0]   valid_n;

    csr_xlat_t               rd_x;
    csr_xlat_t               wr_x;
    logic                    wr_en;
    logic [2*XLEN-1:0]       cycle_inc;

    assign rd_x = csr_translate(rd_req_i.addr);
    assign wr_x = csr_translate(wr_req_i.addr);

    // Read-only and unimplemented targets drop the write
    assign wr_en = wr_req_i.valid && wr_x.impl && !CSR_RO_MASK[wr_x.idx];

    assign cycle_inc = {data_q[CSR_MCYCLEH], data_q[CSR_MCYCLE]} + 1'b1;

    ////////////////////////////////////////
    // Next state, lowest priority first
    ////////////////////////////////////////
    always_comb begin
        data_n  = data_q;
        tag_n   = tag_q;
        valid_n = valid_q;

        data_n[CSR_MCYCLE]  = cycle_inc[XLEN-1:0];
        data_n[CSR_MCYCLEH] = cycle_inc[2*XLEN-1:XLEN];

        // Tagged read renames the CSR
        if (rd_req_i.valid && rd_x.impl) begin
            tag_n[rd_x.idx]   = rd_req_i.tag;
            valid_n[rd_x.idx] = 1'b0;
        end

        if (wr_en) begin
            data_n[wr_x.idx]  = wr_req_i.data;
            valid_n[wr_x.idx] = (wr_req_i.tag == tag_q[wr_x.idx]);  // Pre-edge tag
        end

        if (trap_upd_i.valid) begin
            data_n[CSR_MSTATUS] = trap_upd_i.mstatus;
            if (trap_upd_i.entry) begin
                data_n[CSR_MEPC]   = trap_upd_i.mepc;
                data_n[CSR_MCAUSE] = trap_upd_i.mcause;
                data_n[CSR_MTVAL]  = trap_upd_i.mtval;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < CSR_N_REGS; i++) begin
                data_q[i] <= (i == int'(CSR_MISA)) ? MISA_RESET : '0;
                tag_q[i]  <= '0;
            end
            valid_q <= '1;
        end else begin
            data_q  <= data_n;
            tag_q   <= tag_n;
            valid_q <= valid_n;
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////
    always_comb begin
        rd_rsp_o.data  = '0;
        rd_rsp_o.valid = 1'b0;
        if (rd_x.impl) begin
            rd_rsp_o.data  = data_q[rd_x.idx];
            rd_rsp_o.valid = valid_q[rd_x.idx];
        end
    end

    // Current values for the trap logic
    assign mstatus_o = data_q[CSR_MSTATUS];
    assign mtvec_o   = data_q[CSR_MTVEC];
    assign mepc_o    = data_q[CSR_MEPC];

endmodule

// File: verilog/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic            clk_i,
    input  logic            rstn_i,

    input  exc_req_t        dec_exc_i,
    input  exc_req_t        exe_exc_i,
    input  exc_req_t        mem_exc_i,

    input  logic [XLEN-1:0] mstatus_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i,

    output trap_upd_t       trap_upd_o,
    output redirect_t       redirect_o
);

    exc_req_t        sel_exc;
    logic            is_mret;
    logic [XLEN-1:0] mstatus_entry;
    logic [XLEN-1:0] mstatus_mret;
    logic [XLEN-1:0] target_pc;
    redirect_t       redirect_q;

    ////////////////////////////////////////
    // Priority select
    ////////////////////////////////////////
    always_comb begin
        sel_exc = '0;
        if (mem_exc_i.valid) begin      // Oldest instruction
            sel_exc      = mem_exc_i;
            sel_exc.info = '0;
        end else if (exe_exc_i.valid) begin
            sel_exc      = exe_exc_i;   // Only stage with a trap value
        end else if (dec_exc_i.valid) begin
            sel_exc      = dec_exc_i;
            sel_exc.info = '0;
        end
    end

    assign is_mret = (sel_exc.code == MRET);

    ////////////////////////////////////////
    // New mstatus
    ////////////////////////////////////////
    always_comb begin
        mstatus_entry = mstatus_i;
        mstatus_entry[MSTATUS_MPIE] = mstatus_i[MSTATUS_MIE];
        mstatus_entry[MSTATUS_MIE]  = 1'b0;
        mstatus_entry[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB] = PRIV_M;
    end

    always_comb begin
        mstatus_mret = mstatus_i;
        mstatus_mret[MSTATUS_MIE]  = mstatus_i[MSTATUS_MPIE];
        mstatus_mret[MSTATUS_MPIE] = 1'b1;
    end

    // Written into the CSRs at the same edge as the redirect
    always_comb begin
        trap_upd_o.valid   = sel_exc.valid;
        trap_upd_o.entry   = !is_mret;
        trap_upd_o.mepc    = sel_exc.pc;
        trap_upd_o.mcause  = {{(XLEN-EXC_CODE_BITS){1'b0}}, sel_exc.code};
        trap_upd_o.mtval   = sel_exc.info;
        trap_upd_o.mstatus = is_mret ? mstatus_mret : mstatus_entry;
    end

    ////////////////////////////////////////
    // Fetch redirect
    ////////////////////////////////////////
    assign target_pc = is_mret ? mepc_i : {mtvec_i[XLEN-1:2], 2'b00};  // Direct mode only

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            redirect_q.valid <= 1'b0;
        end else begin
            redirect_q.valid <= sel_exc.valid;
        end
        if (sel_exc.valid) begin
            redirect_q.pc <= target_pc;
        end
    end

    assign redirect_o = redirect_q;

endmodule

// File: verilog/csr_unit_top.sv
`timescale 1ns/1ps

module csr_unit_top
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,

    // Exception reports per stage
    input  exc_req_t    dec_exc_i,
    input  exc_req_t    exe_exc_i,
    input  exc_req_t    mem_exc_i,

    input  csr_rd_req_t csr_rd_req_i,
    input  csr_wr_req_t csr_wr_req_i,

    output csr_rd_rsp_t csr_rd_rsp_o,
    output redirect_t   redirect_o   // Also flushes the pipeline
);

    trap_upd_t       trap_upd;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;

    ////////////////////////////////////////
    // Trap control
    ////////////////////////////////////////
    trap_ctrl u_trap_ctrl (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .dec_exc_i  (dec_exc_i),
        .exe_exc_i  (exe_exc_i),
        .mem_exc_i  (mem_exc_i),
        .mstatus_i  (mstatus),
        .mtvec_i    (mtvec),
        .mepc_i     (mepc),
        .trap_upd_o (trap_upd),
        .redirect_o (redirect_o)
    );

    ////////////////////////////////////////
    // CSR storage
    ////////////////////////////////////////
    csr_file u_csr_file (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rd_req_i   (csr_rd_req_i),
        .wr_req_i   (csr_wr_req_i),
        .trap_upd_i (trap_upd),
        .rd_rsp_o   (csr_rd_rsp_o),
        .mstatus_o  (mstatus),
        .mtvec_o    (mtvec),
        .mepc_o     (mepc)
    );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;  // Released on a falling edge
    end

    always #5 clk_o = ~clk_o;

endmodule

// File: tests/csr_unit_assertions.sv
`timescale 1ns/1ps

module csr_unit_assertions
    import csr_pkg::*;
    import trap_pkg::*;
(
    input logic        clk_i,
    input logic        rstn_i,
    input exc_req_t    dec_exc_i,
    input exc_req_t    exe_exc_i,
    input exc_req_t    mem_exc_i,
    input csr_rd_req_t csr_rd_req_i,
    input csr_rd_rsp_t csr_rd_rsp_o,
    input redirect_t   redirect_o
);

    logic any_exc;
    int   fails = 0;

    assign any_exc = dec_exc_i.valid || exe_exc_i.valid || mem_exc_i.valid;

    // First cycle out of reset
    assert property (@(posedge clk_i) $rose(rstn_i) |-> !redirect_o.valid)
        else begin
            fails++;
            $error("redirect valid right after reset");
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i) any_exc |=> redirect_o.valid)
        else begin
            fails++;
            $error("exception without redirect one cycle later");
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        csr_rd_rsp_o.valid |-> csr_rd_req_i.addr inside {12'hF11, 12'hF12, 12'hF13,
            12'hF14, 12'h300, 12'h301, 12'h304, 12'h305, 12'h310, 12'h340, 12'h341,
            12'h342, 12'h343, 12'hB00, 12'hB80})
        else begin
            fails++;
            $error("read valid for an unimplemented address");
        end

endmodule

bind csr_unit_top csr_unit_assertions u_assertions (.*);

// File: tests/csr_unit_model.svh
`ifndef CSR_UNIT_MODEL_SVH
`define CSR_UNIT_MODEL_SVH

// Index order: ID regs, misa, mstatush (read-only up to 5), then writable ones
logic [CSR_ADDR_BITS-1:0] m_addr  [CSR_N_REGS];
logic [XLEN-1:0]          m_data  [CSR_N_REGS];
logic [CSR_TAG_BITS-1:0]  m_tag   [CSR_N_REGS];
logic                     m_valid [CSR_N_REGS];
redirect_t                m_redir;

function automatic int addr_to_index(input logic [CSR_ADDR_BITS-1:0] addr);
    for (int i = 0; i < CSR_N_REGS; i++) begin
        if (m_addr[i] == addr) return i;
    end
    return -1;
endfunction

function automatic void reset_model();
    m_addr = '{12'hF11, 12'hF12, 12'hF13, 12'hF14, 12'h301, 12'h310, 12'h300, 12'h304,
               12'h305, 12'h340, 12'h341, 12'h342, 12'h343, 12'hB00, 12'hB80};
    for (int i = 0; i < CSR_N_REGS; i++) begin
        m_data[i]  = (i == 4) ? 32'h40001104 : '0;
        m_tag[i]   = '0;
        m_valid[i] = 1'b1;
    end
    m_redir = '0;
endfunction

function automatic csr_rd_rsp_t expected_rd_rsp(input csr_rd_req_t rd);
    csr_rd_rsp_t r;
    int          i;
    i = addr_to_index(rd.addr);
    r = '0;
    if (i >= 0) begin
        r.data  = m_data[i];
        r.valid = m_valid[i];
    end
    return r;
endfunction

// One clock edge with the given inputs
function automatic void advance_model(input csr_rd_req_t rd, input csr_wr_req_t wr,
                                      input exc_req_t d, input exc_req_t e, input exc_req_t m);
    int                      ri;
    int                      wi;
    logic [63:0]             cyc;
    logic [XLEN-1:0]         st;
    logic [XLEN-1:0]         tvec;
    logic [XLEN-1:0]         epc;
    logic [CSR_TAG_BITS-1:0] old_tag;
    exc_req_t                s;
    ri = addr_to_index(rd.addr);
    wi = addr_to_index(wr.addr);
    st = m_data[6];
    tvec = m_data[8];
    epc = m_data[10];
    old_tag = (wi >= 0) ? m_tag[wi] : '0;
    cyc = {m_data[14], m_data[13]} + 64'd1;
    m_data[13] = cyc[31:0];
    m_data[14] = cyc[63:32];
    if (rd.valid && ri >= 0) begin
        m_tag[ri]   = rd.tag;
        m_valid[ri] = 1'b0;
    end
    if (wr.valid && wi > 5) begin
        m_data[wi]  = wr.data;
        m_valid[wi] = (wr.tag == old_tag);
    end
    if (m.valid) begin
        s = m;
        s.info = '0;
    end else if (e.valid) begin
        s = e;                      // Execute keeps its trap value
    end else begin
        s = d;
        s.info = '0;
    end
    m_redir.valid = s.valid;
    if (s.valid) begin
        if (s.code == MRET) begin
            m_redir.pc = epc;
            st[3] = st[7];
            st[7] = 1'b1;
        end else begin
            m_redir.pc = {tvec[31:2], 2'b00};
            st[7] = st[3];
            st[3] = 1'b0;
            st[12:11] = 2'b11;
            m_data[10] = s.pc;
            m_data[11] = {27'd0, s.code};
            m_data[12] = s.info;
        end
        m_data[6] = st;
    end
endfunction

`endif

// File: tests/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb
    import csr_pkg::*;
    import trap_pkg::*;
();

    logic        clk;
    logic        rstn;
    exc_req_t    dec_exc, exe_exc, mem_exc;
    csr_rd_req_t rd_req;
    csr_wr_req_t wr_req;
    csr_rd_rsp_t rd_rsp;
    redirect_t   redir;
    int          errors = 0;
    exc_code_e   codes [7] = '{INSTR_MISALIGNED, ILLEGAL_INSTR, BREAKPOINT, LOAD_MISALIGNED,
                               STORE_MISALIGNED, ECALL_M, MRET};

    `include "csr_unit_model.svh"

    tb_clock_gen u_clk (.clk_o(clk), .rstn_o(rstn));

    csr_unit_top dut0 (
        .clk_i(clk), .rstn_i(rstn),
        .dec_exc_i(dec_exc), .exe_exc_i(exe_exc), .mem_exc_i(mem_exc),
        .csr_rd_req_i(rd_req), .csr_wr_req_i(wr_req),
        .csr_rd_rsp_o(rd_rsp), .redirect_o(redir)
    );

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_rd_rsp(input string name, input csr_rd_rsp_t exp, input csr_rd_rsp_t got);
        if (exp !== got) begin
            errors++;
            $display("FAILED %s: expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t exp, input redirect_t got);
        if (got.valid !== exp.valid || (exp.valid && got.pc !== exp.pc)) begin
            errors++;
            $display("FAILED %s: expected %h got %h", name, exp, got);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    function automatic csr_rd_req_t rd_of(input logic [11:0] addr, input logic [4:0] tag);
        return '{valid: 1'b1, addr: addr, tag: tag};
    endfunction

    function automatic csr_wr_req_t wr_of(input logic [11:0] addr, input logic [4:0] tag,
                                          input logic [31:0] data);
        return '{valid: 1'b1, addr: addr, tag: tag, data: data};
    endfunction

    function automatic exc_req_t exc_of(input logic v, input exc_code_e code);
        return '{valid: v, pc: $urandom, code: code, info: $urandom};
    endfunction

    // Drive on the falling edge, check before the rising edge, then advance the model
    task automatic run_cycle(input csr_rd_req_t rd, input csr_wr_req_t wr, input exc_req_t d,
                             input exc_req_t e, input exc_req_t m, output csr_rd_rsp_t seen);
        @(negedge clk);
        rd_req = rd;
        wr_req = wr;
        dec_exc = d;
        exe_exc = e;
        mem_exc = m;
        #1;
        seen = rd_rsp;
        check_rd_rsp("csr_rd_rsp_o", expected_rd_rsp(rd), rd_rsp);
        check_redirect("redirect_o", m_redir, redir);
        @(posedge clk);
        advance_model(rd, wr, d, e, m);
    endtask

    task automatic idle(input int n);
        csr_rd_rsp_t s;
        repeat (n) run_cycle('0, '0, '0, '0, '0, s);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        csr_rd_rsp_t s, c1;
        int          n;
        int          i;
        void'($urandom(22));
        {dec_exc, exe_exc, mem_exc, rd_req, wr_req} = '0;
        n = 0;
        while (rstn !== 1'b1) begin
            if (n == 20) abort_on_timeout("reset release");
            @(posedge clk);
            n++;
        end
        reset_model();
        advance_model('0, '0, '0, '0, '0);  // First counting edge

        // Reset values
        for (i = 0; i < 5; i++) run_cycle(rd_of(m_addr[i], 5'd0), '0, '0, '0, '0, s);
        check_rd_rsp("misa", '{data: 32'h40001104, valid: 1'b1}, s);

        // Tag protocol on mscratch
        run_cycle(rd_of(12'h340, 5'd7), '0, '0, '0, '0, s);
        run_cycle(rd_of(12'h7C0, 5'd1), wr_of(12'h340, 5'd7, 32'hCAFE0001), '0, '0, '0, s);
        run_cycle(rd_of(12'h340, 5'd3), '0, '0, '0, '0, s);
        check_rd_rsp("mscratch", '{data: 32'hCAFE0001, valid: 1'b1}, s);
        run_cycle(rd_of(12'h340, 5'd3), wr_of(12'h340, 5'd9, 32'h12345678), '0, '0, '0, s);
        run_cycle(rd_of(12'h340, 5'd3), '0, '0, '0, '0, s);

        // Read-only and unimplemented targets
        run_cycle('0, wr_of(12'h301, 5'd0, 32'hFFFFFFFF), '0, '0, '0, s);
        run_cycle(rd_of(12'h301, 5'd0), wr_of(12'h7C0, 5'd0, 32'h1), '0, '0, '0, s);
        run_cycle(rd_of(12'h7C0, 5'd0), '0, '0, '0, '0, s);

        // Trap entry from simultaneous reports
        run_cycle('0, wr_of(12'h305, 5'd0, 32'h00000803), '0, '0, '0, s);
        run_cycle('0, wr_of(12'h300, 5'd0, 32'h00000008), '0, '0, '0, s);
        run_cycle('0, '0, exc_of($urandom % 2, ECALL_M), exc_of(1'b1, ILLEGAL_INSTR),
                  exc_of($urandom % 2, LOAD_MISALIGNED), s);
        #1;
        n = 0;
        while (redir.valid !== 1'b1) begin
            if (n == 4) abort_on_timeout("trap redirect");
            idle(1);
            #1;
            n++;
        end
        check_redirect("redirect_o", '{valid: 1'b1, pc: 32'h00000800}, redir);
        for (i = 10; i < 13; i++) run_cycle(rd_of(m_addr[i], 5'd0), '0, '0, '0, '0, s);
        run_cycle(rd_of(12'h300, 5'd0), '0, '0, '0, '0, s);

        // MRET restores MIE from MPIE
        run_cycle('0, '0, exc_of(1'b1, MRET), '0, '0, s);
        run_cycle(rd_of(12'h300, 5'd0), '0, '0, '0, '0, s);

        // Cycle counter
        run_cycle(rd_of(12'hB00, 5'd0), '0, '0, '0, '0, c1);
        idle(7);
        run_cycle(rd_of(12'hB00, 5'd0), '0, '0, '0, '0, s);
        check_rd_rsp("mcycle", '{data: c1.data + 32'd8, valid: 1'b0}, s);
        run_cycle('0, wr_of(12'hB00, 5'd0, 32'h00000100), '0, '0, '0, s);
        run_cycle(rd_of(12'hB00, 5'd0), '0, '0, '0, '0, s);
        check_rd_rsp("mcycle", '{data: 32'h00000100, valid: 1'b1}, s);

        // Random traffic
        repeat (400) begin
            csr_rd_req_t rr;
            csr_wr_req_t ww;
            int          k;
            k = $urandom % CSR_N_REGS;
            rr = rd_of(($urandom % 8 == 0) ? 12'h7C1 : m_addr[k], $urandom);
            rr.valid = $urandom % 2;
            k = $urandom % CSR_N_REGS;
            ww = wr_of(($urandom % 8 == 0) ? 12'h7C2 : m_addr[k], $urandom, $urandom);
            ww.valid = $urandom % 2;
            if ($urandom % 2) ww.tag = m_tag[k];
            run_cycle(rr, ww, exc_of($urandom % 10 == 0, codes[$urandom % 7]),
                      exc_of($urandom % 10 == 0, codes[$urandom % 7]),
                      exc_of($urandom % 10 == 0, codes[$urandom % 7]), s);
        end
        idle(2);

        $display("Errors: %0d, assertion failures: %0d", errors, dut0.u_assertions.fails);
        if (errors == 0 && dut0.u_assertions.fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+tests
verilog/csr_pkg.sv
verilog/trap_pkg.sv
verilog/csr_file.sv
verilog/trap_ctrl.sv
verilog/csr_unit_top.sv
tests/tb_clock_gen.sv
tests/csr_unit_assertions.sv
tests/csr_unit_tb.sv
